// ==== include/fanout_defines.svh ====
/*
 * fanout unit build parameters
 * port count, data width, per-port counter width
 */

`ifndef FANOUT_DEFINES_SVH
`define FANOUT_DEFINES_SVH

// number of output ports
// header mask bits come from the low data bits, so keep this <= data width
`define FANOUT_PORTS 4

// payload data width in bits
`define FANOUT_DATA_WIDTH 32

// width of each beat and frame counter
// wraps silently on overflow
`define FANOUT_COUNT_WIDTH 16

`endif

// ==== hdl/fanout_pkg.sv ====
/*
 * shared types of the fanout unit
 * beat, port mask, tagged beat, counter value
 */

`include "fanout_defines.svh"

package fanout_pkg;

    // one bit per output port
    typedef logic [`FANOUT_PORTS-1:0] port_mask_t;

    // one counter value
    typedef logic [`FANOUT_COUNT_WIDTH-1:0] count_t;

    // stream beat, data and frame end marker
    typedef struct packed {
        logic [`FANOUT_DATA_WIDTH-1:0] data;
        logic                          last;
    } beat_t;

    // payload beat with the port mask of its frame
    // mask in the upper bits
    typedef struct packed {
        port_mask_t mask;
        beat_t      beat;
    } tagged_beat_t;

endpackage

// ==== hdl/frame_header_decode.sv ====
/*
 * frame header decode
 * strips the header beat, keeps its port mask and
 * tags each payload beat of the frame with that mask
 */

`include "fanout_defines.svh"

module frame_header_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     s_valid,
    input  fanout_pkg::beat_t        s_beat,
    output logic                     s_ready,
    output logic                     t_valid,
    output fanout_pkg::tagged_beat_t t_beat,
    input  logic                     t_ready
);
    import fanout_pkg::*;

    // high while the next input beat is a header
    logic         expect_header;
    // mask of the frame in progress
    port_mask_t   frame_mask;
    // one-entry output register
    logic         t_valid_reg;
    tagged_beat_t t_beat_reg;

    logic s_fire;
    logic payload_fire;
    logic keep_beat;

    // accept when empty or the held beat leaves this cycle
    assign s_ready = !t_valid_reg || t_ready;

    assign s_fire       = s_valid && s_ready;
    assign payload_fire = s_fire && !expect_header;
    // zero mask frames are read and dropped
    assign keep_beat    = payload_fire && (frame_mask != '0);

    assign t_valid = t_valid_reg;
    assign t_beat  = t_beat_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            expect_header <= 1'b1;
            t_valid_reg   <= 1'b0;
        end else begin
            // downstream took the held beat
            if (t_valid_reg && t_ready) begin
                t_valid_reg <= 1'b0;
            end
            if (keep_beat) begin
                t_valid_reg <= 1'b1;
            end
            // last re-arms the header state
            // a header with last set is a frame without payload
            if (s_fire) begin
                expect_header <= s_beat.last;
            end
        end
    end

    // mask and payload registers
    always_ff @(posedge clk) begin
        if (s_fire && expect_header) begin
            frame_mask <= s_beat.data[`FANOUT_PORTS-1:0];
        end
        if (keep_beat) begin
            t_beat_reg.mask <= frame_mask;
            t_beat_reg.beat <= s_beat;
        end
    end

endmodule

// ==== hdl/axis_broadcast.sv ====
/*
 * masked stream broadcast
 * registered output stage plus one skid register,
 * per-port valid, beat retires when all masked ports accept
 */

`include "fanout_defines.svh"

module axis_broadcast #(
    parameter type payload_t = logic [31:0]
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               s_valid,
    input  fanout_pkg::port_mask_t             s_mask,
    input  payload_t                           s_payload,
    output logic                               s_ready,
    output fanout_pkg::port_mask_t             m_valid,
    output payload_t [`FANOUT_PORTS-1:0]       m_payload,
    input  fanout_pkg::port_mask_t             m_ready
);
    import fanout_pkg::*;

    // early ready, registered
    logic       s_ready_reg;
    logic       s_ready_early;

    // output stage
    port_mask_t out_valid_reg;
    port_mask_t out_valid_next;
    port_mask_t out_mask_reg;
    payload_t   out_payload_reg;

    // skid register
    logic       temp_valid_reg;
    logic       temp_valid_next;
    port_mask_t temp_mask_reg;
    payload_t   temp_payload_reg;

    // datapath moves
    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    // high when no masked port is still waiting
    logic out_ready;

    assign out_ready = !(|(out_valid_reg & out_mask_reg & ~m_ready));

    assign s_ready   = s_ready_reg;
    assign m_valid   = out_valid_reg;
    // same beat on every port
    assign m_payload = {`FANOUT_PORTS{out_payload_reg}};

    // ready next cycle if the output drains now
    // or the skid register cannot fill next cycle
    assign s_ready_early = out_ready ||
        (!temp_valid_reg && (!(|out_valid_reg) || !s_valid));

    always_comb begin
        // ports that accept drop their valid
        out_valid_next    = out_valid_reg & ~m_ready;
        temp_valid_next   = temp_valid_reg;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (s_ready_reg) begin
            if (out_ready) begin
                // output free, load straight from input
                out_valid_next  = s_valid ? s_mask : '0;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park input
                temp_valid_next  = s_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            // input held off, drain skid into output
            out_valid_next    = temp_valid_reg ? temp_mask_reg : '0;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_ready_reg    <= 1'b0;
            out_valid_reg  <= '0;
            temp_valid_reg <= 1'b0;
        end else begin
            s_ready_reg    <= s_ready_early;
            out_valid_reg  <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
        end
    end

    // payload and mask registers
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_payload_reg <= s_payload;
            out_mask_reg    <= s_mask;
        end else if (store_temp_to_out) begin
            out_payload_reg <= temp_payload_reg;
            out_mask_reg    <= temp_mask_reg;
        end

        if (store_in_to_temp) begin
            temp_payload_reg <= s_payload;
            temp_mask_reg    <= s_mask;
        end
    end

endmodule

// ==== hdl/port_frame_counter.sv ====
/*
 * per-port delivery counters
 * beats and completed frames on each output port
 */

`include "fanout_defines.svh"

module port_frame_counter (
    input  logic                                   clk,
    input  logic                                   rst,
    input  fanout_pkg::port_mask_t                 m_valid,
    input  fanout_pkg::port_mask_t                 m_ready,
    input  fanout_pkg::port_mask_t                 m_last,
    output fanout_pkg::count_t [`FANOUT_PORTS-1:0] beat_count,
    output fanout_pkg::count_t [`FANOUT_PORTS-1:0] frame_count
);
    import fanout_pkg::*;

    // transfer on each port this cycle
    port_mask_t fire;

    assign fire = m_valid & m_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_count  <= '0;
            frame_count <= '0;
        end else begin
            for (int i = 0; i < `FANOUT_PORTS; i++) begin
                if (fire[i]) begin
                    beat_count[i] <= beat_count[i] + 1'b1;
                    // frame done on its last beat
                    if (m_last[i]) begin
                        frame_count[i] <= frame_count[i] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/stream_fanout_top.sv ====
/*
 * frame fanout top level
 * header decode, masked broadcast, per-port counters
 */

`include "fanout_defines.svh"

module stream_fanout_top (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   s_valid,
    input  fanout_pkg::beat_t                      s_beat,
    output logic                                   s_ready,
    output fanout_pkg::port_mask_t                 m_valid,
    output fanout_pkg::beat_t [`FANOUT_PORTS-1:0]  m_beat,
    input  fanout_pkg::port_mask_t                 m_ready,
    output fanout_pkg::count_t [`FANOUT_PORTS-1:0] beat_count,
    output fanout_pkg::count_t [`FANOUT_PORTS-1:0] frame_count
);

    // decode to broadcast link
    logic                     t_valid;
    logic                     t_ready;
    fanout_pkg::tagged_beat_t t_beat;

    // last bit of each port's beat
    fanout_pkg::port_mask_t   m_last;

    for (genvar i = 0; i < `FANOUT_PORTS; i++) begin : g_last
        assign m_last[i] = m_beat[i].last;
    end

    frame_header_decode u_frame_header_decode (
        .clk     (clk),
        .rst     (rst),
        .s_valid (s_valid),
        .s_beat  (s_beat),
        .s_ready (s_ready),
        .t_valid (t_valid),
        .t_beat  (t_beat),
        .t_ready (t_ready)
    );

    axis_broadcast #(
        .payload_t (fanout_pkg::beat_t)
    ) u_axis_broadcast (
        .clk       (clk),
        .rst       (rst),
        .s_valid   (t_valid),
        .s_mask    (t_beat.mask),
        .s_payload (t_beat.beat),
        .s_ready   (t_ready),
        .m_valid   (m_valid),
        .m_payload (m_beat),
        .m_ready   (m_ready)
    );

    port_frame_counter u_port_frame_counter (
        .clk         (clk),
        .rst         (rst),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_last      (m_last),
        .beat_count  (beat_count),
        .frame_count (frame_count)
    );

endmodule

// ==== verification/stream_fanout_checker.sv ====
/*
 * handshake assertions for the masked broadcast
 * bound into every axis_broadcast instance
 */

`include "fanout_defines.svh"

module stream_fanout_checker #(
    parameter int PAYLOAD_W = 33
) (
    input logic                               clk,
    input logic                               rst,
    input logic                               s_valid,
    input fanout_pkg::port_mask_t             s_mask,
    input logic                               s_ready,
    input fanout_pkg::port_mask_t             m_valid,
    input fanout_pkg::port_mask_t             m_ready,
    input logic [`FANOUT_PORTS*PAYLOAD_W-1:0] m_payload
);

    // input side held off while in reset
    a_ready_in_reset : assert property (@(posedge clk) rst |=> !s_ready)
        else $error("s_ready high after a reset cycle");

    // beat taken while the output drains
    // valid next cycle on exactly the ports of its mask
    a_valid_in_mask : assert property (@(posedge clk) disable iff (rst)
        s_valid && s_ready && ((m_valid & ~m_ready) == '0) |=> m_valid == $past(s_mask))
        else $error("m_valid %h is not the mask of the beat loaded a cycle earlier", m_valid);

    for (genvar i = 0; i < `FANOUT_PORTS; i++) begin : g_port
        // stalled beat stays put until this port takes it
        a_hold_until_ready : assert property (@(posedge clk) disable iff (rst)
            m_valid[i] && !m_ready[i] |=>
                m_valid[i] && $stable(m_payload[i*PAYLOAD_W +: PAYLOAD_W]))
            else $error("port %0d changed or dropped a beat before acceptance", i);
    end

endmodule

bind axis_broadcast stream_fanout_checker #(
    .PAYLOAD_W ($bits(payload_t))
) u_stream_fanout_checker (
    .clk       (clk),
    .rst       (rst),
    .s_valid   (s_valid),
    .s_mask    (s_mask),
    .s_ready   (s_ready),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_payload (m_payload)
);

// ==== verification/stream_fanout_tb.sv ====
/*
 * testbench for the frame fanout unit
 * pattern-file frames, random stalls on both sides,
 * per-port scoreboards and final counter checks
 */

`include "fanout_defines.svh"

module stream_fanout_tb;
    import fanout_pkg::*;

    localparam int          PORTS      = `FANOUT_PORTS;
    localparam int          PAT_DEPTH  = 256;
    localparam int          CLK_HALF   = 2;
    localparam int          CLK_PERIOD = 2 * CLK_HALF;
    // watchdog budget per pattern word
    localparam int          WORD_CYCLES = 40;
    localparam logic [31:0] END_MARK   = 32'hffff_ffff;

    logic               clk;
    logic               rst;
    logic               s_valid;
    beat_t              s_beat;
    logic               s_ready;
    port_mask_t         m_valid;
    beat_t [PORTS-1:0]  m_beat;
    port_mask_t         m_ready;
    count_t [PORTS-1:0] beat_count;
    count_t [PORTS-1:0] frame_count;

    // raw words from the pattern file
    logic [31:0] pat_mem [PAT_DEPTH];
    // input beats with the header first in each frame
    beat_t       in_q[$];
    // expected beats per output port
    beat_t       exp_q[PORTS][$];
    int          exp_beats[PORTS];
    int          exp_frames[PORTS];
    int          pat_words;
    logic        loaded;

    stream_fanout_top u_stream_fanout_top (
        .clk         (clk),
        .rst         (rst),
        .s_valid     (s_valid),
        .s_beat      (s_beat),
        .s_ready     (s_ready),
        .m_valid     (m_valid),
        .m_beat      (m_beat),
        .m_ready     (m_ready),
        .beat_count  (beat_count),
        .frame_count (frame_count)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run stopped at first error");
    endtask

    // each frame is a header word, a length and the payload words
    task automatic load_patterns();
        int         ptr;
        int         len;
        port_mask_t mask;
        beat_t      b;
        ptr = 0;
        $readmemh("verification/stream_fanout_patterns.txt", pat_mem);
        while (pat_mem[ptr] !== END_MARK) begin
            assert (ptr + 2 < PAT_DEPTH)
                else stop_on_error("pattern file has no end marker");
            // only the low header bits select ports
            mask   = pat_mem[ptr][PORTS-1:0];
            len    = int'(pat_mem[ptr + 1]);
            b.data = pat_mem[ptr];
            b.last = 1'b0;
            in_q.push_back(b);
            for (int w = 0; w < len; w++) begin
                b.data = pat_mem[ptr + 2 + w];
                b.last = (w == len - 1);
                in_q.push_back(b);
                for (int p = 0; p < PORTS; p++) begin
                    if (mask[p]) begin
                        exp_q[p].push_back(b);
                        exp_beats[p]++;
                        if (b.last) begin
                            exp_frames[p]++;
                        end
                    end
                end
            end
            ptr += 2 + len;
        end
        pat_words = ptr;
        // totals after the marker must agree with the frames
        for (int p = 0; p < PORTS; p++) begin
            assert (int'(pat_mem[ptr + 1 + p]) == exp_beats[p])
                else stop_on_error($sformatf("pattern file beat total for port %0d is wrong", p));
            assert (int'(pat_mem[ptr + 1 + PORTS + p]) == exp_frames[p])
                else stop_on_error($sformatf("pattern file frame total for port %0d is wrong", p));
        end
    endtask

    // valid held until accepted
    // random idle cycles between beats
    task automatic drive_frames();
        beat_t b;
        while (in_q.size() > 0) begin
            b = in_q.pop_front();
            while ($urandom_range(3) == 0) begin
                @(posedge clk);
                #1;
            end
            s_valid = 1'b1;
            s_beat  = b;
            @(negedge clk);
            while (!s_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            s_valid = 1'b0;
        end
    endtask

    task automatic check_port_beat(input int port);
        beat_t want;
        assert (exp_q[port].size() > 0)
            else stop_on_error($sformatf("port %0d delivered a beat no frame sent to it", port));
        want = exp_q[port].pop_front();
        assert (m_beat[port].data == want.data)
            else stop_on_error($sformatf("ERROR m_beat[%0d].data = %h, expected %h",
                port, m_beat[port].data, want.data));
        assert (m_beat[port].last == want.last)
            else stop_on_error($sformatf("ERROR m_beat[%0d].last = %h, expected %h",
                port, m_beat[port].last, want.last));
    endtask

    function automatic bit queues_empty();
        for (int p = 0; p < PORTS; p++) begin
            if (exp_q[p].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic check_counters();
        for (int p = 0; p < PORTS; p++) begin
            assert (int'(beat_count[p]) == exp_beats[p])
                else stop_on_error($sformatf("ERROR beat_count[%0d] = %h, expected %h",
                    p, beat_count[p], exp_beats[p]));
            assert (int'(frame_count[p]) == exp_frames[p])
                else stop_on_error($sformatf("ERROR frame_count[%0d] = %h, expected %h",
                    p, frame_count[p], exp_frames[p]));
        end
    endtask

    // random ready per port, high three cycles in four
    initial begin
        m_ready = '0;
        forever begin
            @(posedge clk);
            #1;
            for (int i = 0; i < PORTS; i++) begin
                m_ready[i] = ($urandom_range(3) != 0);
            end
        end
    end

    // outputs sampled mid cycle
    // the transfer itself happens on the next edge
    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < PORTS; i++) begin
                if (m_valid[i] && m_ready[i]) begin
                    check_port_beat(i);
                end
            end
        end
    end

    initial begin
        wait (loaded);
        #(pat_words * WORD_CYCLES * CLK_PERIOD);
        $display("timeout, frames still in flight after %0d cycles", pat_words * WORD_CYCLES);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'h7f1b));
        rst     = 1'b1;
        s_valid = 1'b0;
        s_beat  = '0;
        loaded  = 1'b0;
        load_patterns();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // idle state straight after reset
        @(negedge clk);
        assert (m_valid == '0)
            else stop_on_error($sformatf("ERROR m_valid = %h after reset, expected 0", m_valid));
        for (int p = 0; p < PORTS; p++) begin
            assert (beat_count[p] == '0)
                else stop_on_error($sformatf("ERROR beat_count[%0d] = %h after reset, expected 0",
                    p, beat_count[p]));
            assert (frame_count[p] == '0)
                else stop_on_error($sformatf("ERROR frame_count[%0d] = %h after reset, expected 0",
                    p, frame_count[p]));
        end
        @(posedge clk);
        #1;
        drive_frames();
        while (!queues_empty()) begin
            @(negedge clk);
        end
        // counters move one edge after the final transfer
        @(posedge clk);
        @(negedge clk);
        assert (m_valid == '0)
            else stop_on_error($sformatf("ERROR m_valid = %h after drain, expected 0", m_valid));
        check_counters();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== verification/stream_fanout_patterns.txt ====
// frame line, hex: header word (low 4 bits are the port mask), payload length, payload words
// after ffffffff: beat totals for ports 0..3, then frame totals for ports 0..3
00000001 3 00000101 00000102 00000103
0000000f 2 aa000001 aa000002
00000000 3 dead0001 dead0002 dead0003
00000006 4 60000001 60000002 60000003 60000004
00000008 1 80000001
0000000a 5 a0000001 a0000002 a0000003 a0000004 a0000005
00000000 1 dead0100
00000005 3 50000001 50000002 50000003
0000000f 6 f0000001 f0000002 f0000003 f0000004 f0000005 f0000006
00000003 2 30000001 30000002
000001f4 3 40000001 40000002 40000003
ffffffff
10 13 12 e
5 5 5 4

// ==== filelist.f ====
+incdir+include
hdl/fanout_pkg.sv
hdl/frame_header_decode.sv
hdl/axis_broadcast.sv
hdl/port_frame_counter.sv
hdl/stream_fanout_top.sv
verification/stream_fanout_checker.sv
verification/stream_fanout_tb.sv

// ==== Makefile ====
# frame fanout unit, Verilator simulation

VERILATOR  ?= verilator
TOP        := stream_fanout_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR) --top-module $(TOP)
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)
SOURCES    := $(wildcard hdl/*.sv include/*.svh verification/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# exit status of the simulation is the test result
run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
